//--- w_rot_pkg.sv
package w_rot_pkg;

  // ####################################################################
  // sizes
  // ####################################################################

  localparam int word_width = 8;
  localparam int lanes      = 4;
  localparam int beat_width = word_width * lanes;

  localparam int kh_max     = 3;  // odd kernel heights only
  localparam int cin_max    = 8;
  localparam int blocks_max = 16;
  localparam int bank_depth = kh_max * cin_max;  // weight beats held per bank

  localparam int bits_addr   = $clog2(bank_depth);
  localparam int bits_kh     = $clog2(kh_max);
  localparam int bits_cin    = $clog2(cin_max);
  localparam int bits_blocks = $clog2(blocks_max);

  // ####################################################################
  // output tuser layout
  // ####################################################################

  localparam int tuser_width    = 3;
  localparam int tuser_top      = 0;
  localparam int tuser_bottom   = 1;
  localparam int tuser_cin_last = 2;

  // ####################################################################
  // beat formats
  // ####################################################################

  // every count is stored minus one
  typedef struct packed {
    logic [beat_width-bits_blocks-bits_cin-bits_kh-1:0] pad;
    logic [bits_blocks-1:0]                             blocks_1;
    logic [bits_cin-1:0]                                cin_1;
    logic [bits_kh-1:0]                                 kh_1;
  } w_cfg_t;

  // first beat of a packet is read as cfg, the rest as weight words
  typedef union packed {
    w_cfg_t                             cfg;
    logic [lanes-1:0][word_width-1:0]   words;
  } w_beat_t;

endpackage

//--- w_bank_ram.sv
`timescale 1ns/1ps

module w_bank_ram import w_rot_pkg::*; (
  input  logic                  aclk,
  input  logic                  wr_en,
  input  logic [bits_addr:0]    wr_addr,
  input  logic [beat_width-1:0] wr_data,
  input  logic                  rd_en,
  input  logic [bits_addr:0]    rd_addr,
  output logic [beat_width-1:0] rd_data
);

  // the top address bit picks the bank
  logic [beat_width-1:0] mem [0:1][0:bank_depth-1];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wr_addr[bits_addr]][wr_addr[bits_addr-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr[bits_addr]][rd_addr[bits_addr-1:0]];  // one cycle read
    end
  end

endmodule

//--- w_rot_ctrl.sv
`timescale 1ns/1ps

module w_rot_ctrl import w_rot_pkg::*; (
  input  logic   aclk,
  input  logic   reset,
  input  logic   wr_done,
  input  w_cfg_t wr_cfg,
  output logic   wr_bank,
  output logic   wr_allow,
  input  logic   rd_done,
  output logic   rd_start,
  output logic   rd_bank,
  output w_cfg_t rd_cfg
);

  logic [1:0] full;
  logic [1:0] full_nx;
  w_cfg_t     cfg_q [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic       rd_ptr_nx;
  logic       rd_active;
  logic       act_nx;
  logic       start_nx;

  // ####################################################################
  // next state of the bank flags
  // ####################################################################

  // both done pulses never hit the same bank in one cycle
  always_comb begin
    full_nx = full;
    if (wr_done) full_nx[wr_ptr] = 1'b1;
    if (rd_done) full_nx[rd_ptr] = 1'b0;
  end

  assign rd_ptr_nx = rd_done ? ~rd_ptr : rd_ptr;
  assign act_nx    = rd_active & ~rd_done;
  assign start_nx  = ~act_nx & full_nx[rd_ptr_nx];  // next bank already loaded and reader idle

  always_ff @(posedge aclk) begin
    if (reset) begin
      full      <= '0;
      wr_ptr    <= 1'b0;
      rd_ptr    <= 1'b0;
      rd_active <= 1'b0;
      rd_start  <= 1'b0;
    end else begin
      full      <= full_nx;
      rd_ptr    <= rd_ptr_nx;
      rd_active <= act_nx | start_nx;
      rd_start  <= start_nx;
      if (wr_done) wr_ptr <= ~wr_ptr;
    end
  end

  always_ff @(posedge aclk) begin
    if (wr_done) cfg_q[wr_ptr] <= wr_cfg;  // cfg travels with its bank
  end

  assign wr_bank  = wr_ptr;
  assign wr_allow = ~full[wr_ptr];
  assign rd_bank  = rd_ptr;
  assign rd_cfg   = cfg_q[rd_ptr];  // steady until rd_done moves the pointer

endmodule

//--- w_write_path.sv
`timescale 1ns/1ps

module w_write_path import w_rot_pkg::*; (
  input  logic                  aclk,
  input  logic                  reset,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic [beat_width-1:0] s_axis_tdata,
  input  logic                  s_axis_tlast,
  input  logic                  wr_allow,
  input  logic                  wr_bank,
  output logic                  wr_en,
  output logic [bits_addr:0]    wr_addr,
  output logic [beat_width-1:0] wr_data,
  output logic                  wr_done,
  output w_cfg_t                wr_cfg
);

  w_beat_t              beat;
  logic                 cfg_phase;  // next beat is a configuration word
  logic                 fire;
  logic [bits_addr-1:0] addr;

  assign s_axis_tready = wr_allow;
  assign fire          = s_axis_tvalid & wr_allow;
  assign beat          = s_axis_tdata;

  // ####################################################################
  // packet tracking
  // ####################################################################

  always_ff @(posedge aclk) begin
    if (reset) begin
      cfg_phase <= 1'b1;
      addr      <= '0;
    end else if (fire) begin
      cfg_phase <= s_axis_tlast;  // a new packet starts after every tlast
      if (cfg_phase || s_axis_tlast) begin
        addr <= '0;
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (fire && cfg_phase) wr_cfg <= beat.cfg;
  end

  // ####################################################################
  // RAM write
  // ####################################################################

  assign wr_en   = fire & ~cfg_phase;
  assign wr_addr = {wr_bank, addr};
  assign wr_data = beat.words;
  assign wr_done = wr_en & s_axis_tlast;  // same cycle as the last weight beat

endmodule

//--- w_read_path.sv
`timescale 1ns/1ps

module w_read_path import w_rot_pkg::*; (
  input  logic                   aclk,
  input  logic                   reset,
  input  logic                   rd_start,
  input  logic                   rd_bank,
  input  w_cfg_t                 rd_cfg,
  output logic                   rd_done,
  output logic                   rd_en,
  output logic [bits_addr:0]     rd_addr,
  input  logic [beat_width-1:0]  rd_data,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic [beat_width-1:0]  m_axis_tdata,
  output logic [tuser_width-1:0] m_axis_tuser,
  output logic                   m_axis_tlast
);

  logic                   iss_act;
  logic [bits_blocks-1:0] pass;
  logic [bits_kh-1:0]     kh;
  logic [bits_cin-1:0]    cin;
  logic [bits_addr-1:0]   offset;
  logic                   row_end;
  logic                   pass_end;
  logic                   iss_last;
  logic [tuser_width-1:0] iss_user;
  logic                   pend;  // RAM read in flight
  logic [tuser_width-1:0] pend_user;
  logic                   pend_last;
  logic [1:0]             cnt;
  logic [1:0]             used;
  logic                   wptr;
  logic                   rptr;
  logic                   pop;
  logic [beat_width-1:0]  buf_data [2];
  logic [tuser_width-1:0] buf_user [2];
  logic                   buf_last [2];

  // ####################################################################
  // address issue
  // ####################################################################

  assign pop   = m_axis_tvalid & m_axis_tready;
  assign used  = cnt + {1'b0, pend} - {1'b0, pop};
  assign rd_en = (iss_act | rd_start) & (used < 2'd2);  // starts in the rd_start cycle itself

  assign row_end  = cin == rd_cfg.cin_1;
  assign pass_end = row_end & (kh == rd_cfg.kh_1);
  assign iss_last = pass_end & (pass == rd_cfg.blocks_1);
  assign rd_addr  = {rd_bank, offset};

  always_comb begin
    iss_user                 = '0;
    iss_user[tuser_top]      = pass == '0;
    iss_user[tuser_bottom]   = pass == rd_cfg.blocks_1;
    iss_user[tuser_cin_last] = row_end;
  end

  // counters wrap to zero on the final issue, ready for the next packet
  always_ff @(posedge aclk) begin
    if (reset) begin
      iss_act <= 1'b0;
      pass    <= '0;
      kh      <= '0;
      cin     <= '0;
      offset  <= '0;
    end else begin
      if (rd_start) iss_act <= 1'b1;
      if (rd_en) begin
        cin    <= row_end ? '0 : cin + 1'b1;
        offset <= pass_end ? '0 : offset + 1'b1;
        if (row_end) kh <= pass_end ? '0 : kh + 1'b1;
        if (pass_end) pass <= iss_last ? '0 : pass + 1'b1;
        if (iss_last) iss_act <= 1'b0;
      end
    end
  end

  // ####################################################################
  // flags alongside the RAM latency, then the two-entry buffer
  // ####################################################################

  always_ff @(posedge aclk) begin
    if (reset) begin
      pend <= 1'b0;
      cnt  <= '0;
      wptr <= 1'b0;
      rptr <= 1'b0;
    end else begin
      pend <= rd_en;
      cnt  <= used;  // room was reserved at issue so this never overflows
      if (pend) wptr <= ~wptr;
      if (pop) rptr <= ~rptr;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_en) begin
      pend_user <= iss_user;
      pend_last <= iss_last;
    end
    if (pend) begin
      buf_data[wptr] <= rd_data;
      buf_user[wptr] <= pend_user;
      buf_last[wptr] <= pend_last;
    end
  end

  assign m_axis_tvalid = cnt != '0;
  assign m_axis_tdata  = buf_data[rptr];
  assign m_axis_tuser  = buf_user[rptr];
  assign m_axis_tlast  = m_axis_tvalid & buf_last[rptr];
  assign rd_done       = pop & m_axis_tlast;

endmodule

//--- weight_rotator.sv
`timescale 1ns/1ps

module weight_rotator import w_rot_pkg::*; (
  input  logic                   aclk,
  input  logic                   reset,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  logic [beat_width-1:0]  s_axis_tdata,
  input  logic                   s_axis_tlast,
  output logic                   m_axis_tvalid,
  input  logic                   m_axis_tready,
  output logic [beat_width-1:0]  m_axis_tdata,
  output logic [tuser_width-1:0] m_axis_tuser,
  output logic                   m_axis_tlast
);

  logic                  wr_allow;
  logic                  wr_bank;
  logic                  wr_en;
  logic [bits_addr:0]    wr_addr;
  logic [beat_width-1:0] wr_data;
  logic                  wr_done;
  w_cfg_t                wr_cfg;
  logic                  rd_start;
  logic                  rd_bank;
  w_cfg_t                rd_cfg;
  logic                  rd_done;
  logic                  rd_en;
  logic [bits_addr:0]    rd_addr;
  logic [beat_width-1:0] rd_data;

  w_rot_ctrl ctrl0 (
    .aclk, .reset, .wr_done, .wr_cfg, .wr_bank, .wr_allow,
    .rd_done, .rd_start, .rd_bank, .rd_cfg
  );

  w_write_path wpath0 (
    .aclk, .reset, .s_axis_tvalid, .s_axis_tready, .s_axis_tdata, .s_axis_tlast,
    .wr_allow, .wr_bank, .wr_en, .wr_addr, .wr_data, .wr_done, .wr_cfg
  );

  w_bank_ram ram0 (
    .aclk, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
  );

  w_read_path rpath0 (
    .aclk, .reset, .rd_start, .rd_bank, .rd_cfg, .rd_done, .rd_en, .rd_addr, .rd_data,
    .m_axis_tvalid, .m_axis_tready, .m_axis_tdata, .m_axis_tuser, .m_axis_tlast
  );

endmodule

//--- weight_rotator_assert.sv
`timescale 1ns/1ps

module weight_rotator_assert import w_rot_pkg::*; (
  input logic                   aclk,
  input logic                   reset,
  input logic                   m_axis_tvalid,
  input logic                   m_axis_tready,
  input logic [beat_width-1:0]  m_axis_tdata,
  input logic [tuser_width-1:0] m_axis_tuser,
  input logic                   m_axis_tlast
);

  // a stalled beat keeps its whole payload
  a_hold: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
      && $stable(m_axis_tuser) && $stable(m_axis_tlast))
    else $error("output beat changed while stalled");

  // the closing beat is the end of a kernel row in the last pass
  a_last: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tlast |-> m_axis_tvalid && m_axis_tuser[tuser_bottom]
      && m_axis_tuser[tuser_cin_last])
    else $error("m_axis_tlast high outside the last row of the last pass");

  a_reset: assert property (@(posedge aclk) reset |=> !m_axis_tvalid)
    else $error("m_axis_tvalid high after reset");

endmodule

bind weight_rotator weight_rotator_assert wra0 (.*);

//--- tb_weight_rotator.sv
`timescale 1ns/1ps

module tb_weight_rotator import w_rot_pkg::*; ();

  logic                   aclk;
  logic                   reset;
  logic                   s_axis_tvalid;
  logic                   s_axis_tready;
  logic [beat_width-1:0]  s_axis_tdata;
  logic                   s_axis_tlast;
  logic                   m_axis_tvalid;
  logic                   m_axis_tready;
  logic [beat_width-1:0]  m_axis_tdata;
  logic [tuser_width-1:0] m_axis_tuser;
  logic                   m_axis_tlast;

  logic [beat_width-1:0]  in_data [$];
  logic                   in_last [$];
  logic [beat_width-1:0]  exp_data [$];
  logic [tuser_width-1:0] exp_user [$];
  logic                   exp_last [$];
  logic                   stim_loaded = 1'b0;
  integer                 seed;

  weight_rotator dut0 (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // ####################################################################
  // helpers
  // ####################################################################

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_data(input logic [beat_width-1:0] got,
                            input logic [beat_width-1:0] exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("error m_axis_tdata beat %0d: got %h expected %h", idx, got, exp));
    end
  endtask

  task automatic check_user(input logic [tuser_width-1:0] got,
                            input logic [tuser_width-1:0] exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("error m_axis_tuser beat %0d: got %h expected %h", idx, got, exp));
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("error m_axis_tlast beat %0d: got %h expected %h", idx, got, exp));
    end
  endtask

  task automatic load_stim();
    int                     fd;
    int                     code;
    string                  tag;
    string                  skip;
    logic [beat_width-1:0]  d;
    logic [tuser_width-1:0] u;
    logic                   l;
    fd = $fopen("weight_rotator_stim.txt", "r");
    if (fd == 0) begin
      abort_run("could not open weight_rotator_stim.txt");
    end else begin
      while ($fscanf(fd, "%s", tag) == 1) begin
        if (tag == "I") begin
          code = $fscanf(fd, "%h %h", d, l);
          if (code != 2) begin
            abort_run("an input line in weight_rotator_stim.txt is malformed");
          end
          in_data.push_back(d);
          in_last.push_back(l);
        end else if (tag == "E") begin
          code = $fscanf(fd, "%h %h %h", d, u, l);
          if (code != 3) begin
            abort_run("an expected line in weight_rotator_stim.txt is malformed");
          end
          exp_data.push_back(d);
          exp_user.push_back(u);
          exp_last.push_back(l);
        end else begin
          code = $fgets(skip, fd);  // rest of a comment line
        end
      end
      $fclose(fd);
    end
  endtask

  // ####################################################################
  // stimulus and output checks
  // ####################################################################

  initial begin : run
    int   in_idx;
    int   out_idx;
    int   held;
    logic took;
    in_idx        = 0;
    out_idx       = 0;
    held          = 0;
    seed          = 32'h691d;
    reset         = 1'b1;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    load_stim();
    stim_loaded = 1'b1;
    repeat (8) @(posedge aclk);
    #2 reset = 1'b0;
    while (out_idx < exp_data.size()) begin
      @(posedge aclk);
      took = s_axis_tvalid & s_axis_tready;
      if (s_axis_tvalid && !s_axis_tready) held++;  // a full bank is holding off the input
      if (took) in_idx++;
      if (m_axis_tvalid && m_axis_tready) begin
        check_data(m_axis_tdata, exp_data[out_idx], out_idx);
        check_user(m_axis_tuser, exp_user[out_idx], out_idx);
        check_last(m_axis_tlast, exp_last[out_idx], out_idx);
        out_idx++;
      end
      #2;
      // a beat on offer stays put until it is taken
      if (took || !s_axis_tvalid) begin
        s_axis_tvalid = (in_idx < in_data.size()) && (($random(seed) & 7) != 0);
        if (in_idx < in_data.size()) begin
          s_axis_tdata = in_data[in_idx];
          s_axis_tlast = in_last[in_idx];
        end
      end
      m_axis_tready = ($random(seed) & 1) != 0;
    end
    @(posedge aclk);
    if (in_idx != in_data.size() || held == 0 || m_axis_tvalid) begin
      abort_run($sformatf("run ended wrong: %0d of %0d input beats taken, %0d held cycles, %s",
                          in_idx, in_data.size(), held,
                          m_axis_tvalid ? "extra output beat" : "no extra output"));
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  initial begin : watchdog
    wait (stim_loaded);
    repeat (exp_data.size() * 40 + 200) @(posedge aclk);
    abort_run("output stalled before all expected beats arrived");
  end

endmodule

//--- weight_rotator_stim.txt
# I <tdata> <tlast>          input beat, the first of each packet is the config word
# E <tdata> <tuser> <tlast>  expected output beat, tuser bits are cin_last bottom top
I 00000004 0
I 11223344 0
I 55667788 1
E 11223344 3 0
E 55667788 7 1
I 00000044 0
I a0a1a2a3 0
I b0b1b2b3 1
E a0a1a2a3 1 0
E b0b1b2b3 5 0
E a0a1a2a3 0 0
E b0b1b2b3 4 0
E a0a1a2a3 2 0
E b0b1b2b3 6 1
I 00000021 0
I c0c1c2c3 0
I d0d1d2d3 1
E c0c1c2c3 5 0
E d0d1d2d3 5 0
E c0c1c2c3 6 0
E d0d1d2d3 6 1
I 00000000 0
I e0e1e2e3 1
E e0e1e2e3 7 1

//--- all.f
w_rot_pkg.sv
w_bank_ram.sv
w_rot_ctrl.sv
w_write_path.sv
w_read_path.sv
weight_rotator.sv
weight_rotator_assert.sv
tb_weight_rotator.sv

//--- Bender.yml
package:
  name: weight_rotator

sources:
  - w_rot_pkg.sv
  - w_bank_ram.sv
  - w_rot_ctrl.sv
  - w_write_path.sv
  - w_read_path.sv
  - weight_rotator.sv
  - target: simulation
    files:
      - weight_rotator_assert.sv
      - tb_weight_rotator.sv
